//--- tests/splicer_input.txt
// columns: tuser, 48-bit pixel in hex, keep (1 if the beat must come out again)
// two stray beats, a frame cut short by a new sof, one full 8x4 frame, then a new sof
0 0000deadbee0 0
0 0000deadbee1 0
1 a00000000000 0
0 a00000000001 0
0 a00000000002 0
1 5a0f1e2d3c00 1
0 5a0f1e2d3c01 1
0 5a0f1e2d3c02 1
0 5a0f1e2d3c03 1
0 5a0f1e2d3c04 1
0 5a0f1e2d3c05 1
0 5a0f1e2d3c06 1
0 5a0f1e2d3c07 1
0 b4e1c2d39610 1
0 b4e1c2d39611 1
0 b4e1c2d39612 1
0 b4e1c2d39613 1
0 b4e1c2d39614 1
0 b4e1c2d39615 1
0 b4e1c2d39616 1
0 b4e1c2d39617 1
0 7788990011a0 1
0 7788990011a1 1
0 7788990011a2 1
0 7788990011a3 1
0 7788990011a4 1
0 7788990011a5 1
0 7788990011a6 1
0 7788990011a7 1
0 fedcba987630 1
0 fedcba987631 1
0 fedcba987632 1
0 fedcba987633 1
0 fedcba987634 1
0 fedcba987635 1
0 fedcba987636 1
0 fedcba987637 1
1 6b0000000000 0
0 6b0000000001 0

//--- flist.f
+incdir+common
common/splicer_pkg.sv
src/stream_fifo.sv
frame_buffer/frame_ram.sv
frame_buffer/frame_writer.sv
frame_buffer/frame_reader.sv
src/splicer.sv
tests/tb_splicer.sv

//--- Bender.yml
package:
  name: splicer

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/splicer_pkg.sv
      - src/stream_fifo.sv
      - frame_buffer/frame_ram.sv
      - frame_buffer/frame_writer.sv
      - frame_buffer/frame_reader.sv
      - src/splicer.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_splicer.sv

//--- tests/tb_splicer.sv
`timescale 1ns/1ps
`include "splicer_defines.svh"

module tb_splicer
  import splicer_pkg::*;
();

  localparam int TIMEOUT = 2000;

  logic   aclk;
  logic   aresetn;
  pixel_t s_axis_tdata;
  logic   s_axis_tvalid;
  logic   s_axis_tuser;
  logic   s_axis_tlast;
  logic   s_axis_tready;
  pixel_t m_axis_tdata;
  logic   m_axis_tvalid;
  logic   m_axis_tuser;
  logic   m_axis_tlast;
  logic   m_axis_tready;

  // beats from the data file in file order
  logic   in_user [$];
  pixel_t in_pix [$];
  logic   in_keep [$];
  pixel_t exp_pix [$];

  int out_count;
  int in_idx;
  int kept_in;
  int check_count;
  int err_count;
  int other_errs;

  splicer u_splicer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // one clock edge with a fresh random ready on the output side
  task automatic tick();
    @(posedge aclk);
    m_axis_tready <= ($urandom_range(3, 0) != 0);
  endtask

  task automatic load_input();
    int     fd;
    int     n;
    string  line;
    logic   user;
    pixel_t pix;
    logic   keep;
    fd = $fopen("tests/splicer_input.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open the data file tests/splicer_input.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // comment and blank lines do not scan as three fields
        if (n > 0 && $sscanf(line, "%h %h %h", user, pix, keep) == 3) begin
          in_user.push_back(user);
          in_pix.push_back(pix);
          in_keep.push_back(keep);
          if (keep) begin
            exp_pix.push_back(pix);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_beat(input logic user, input pixel_t pix, output bit ok);
    int gap;
    int waited;
    gap = $urandom_range(2, 0);
    s_axis_tvalid <= 1'b0;
    repeat (gap) tick();
    s_axis_tvalid <= 1'b1;
    s_axis_tuser  <= user;
    s_axis_tdata  <= pix;
    waited = 0;
    tick();
    while (!s_axis_tready && waited < TIMEOUT) begin
      tick();
      waited++;
    end
    if (s_axis_tready) begin
      ok = 1'b1;
    end else begin
      ok = 1'b0;
      other_errs++;
      $display("timed out waiting for s_axis_tready on input beat %0d", in_idx);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (aresetn) begin
      // held frame stalls the input until at most a fifo's worth is left
      if (kept_in > 0 && kept_in % `SPLICER_FRAME_SIZE == 0 &&
          out_count + `SPLICER_FIFO_DEPTH < kept_in) begin
        check(s_axis_tready, 1'b0, "s_axis_tready while frame held");
      end
      if (s_axis_tvalid && s_axis_tready && in_idx < in_keep.size()) begin
        if (in_keep[in_idx]) begin
          kept_in++;
        end
        in_idx++;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (out_count < exp_pix.size()) begin
          check(m_axis_tdata, exp_pix[out_count], "m_axis_tdata");
          check(m_axis_tuser, (out_count % `SPLICER_FRAME_SIZE) == 0, "m_axis_tuser");
          check(m_axis_tlast,
                (out_count % `SPLICER_FRAME_WIDTH) == `SPLICER_FRAME_WIDTH - 1,
                "m_axis_tlast");
        end else begin
          other_errs++;
          $display("output beat %0d arrived beyond the %0d expected beats",
                   out_count, exp_pix.size());
        end
        out_count++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    int waited;
    bit sent_ok;
    void'($urandom(32'h2a12_5750));
    aresetn       = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tuser  = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    load_input();
    repeat (8) tick();
    aresetn <= 1'b1;

    // quiet outputs before the first beat
    repeat (4) begin
      tick();
      check(m_axis_tvalid, 1'b0, "m_axis_tvalid after reset");
      check(s_axis_tready, 1'b1, "s_axis_tready after reset");
    end

    sent_ok = 1'b1;
    for (i = 0; i < in_pix.size() && sent_ok; i++) begin
      send_beat(in_user[i], in_pix[i], sent_ok);
    end
    s_axis_tvalid <= 1'b0;

    waited = 0;
    while (out_count < exp_pix.size() && waited < TIMEOUT) begin
      tick();
      waited++;
    end
    if (out_count < exp_pix.size()) begin
      other_errs++;
      $display("timed out waiting for output beats, %0d of %0d arrived",
               out_count, exp_pix.size());
    end

    // partial frame at the end of the file must never come out
    repeat (40) tick();
    check(out_count, exp_pix.size(), "output beat count");

    $display("checks %0d, value errors %0d, other errors %0d",
             check_count, err_count, other_errs);
    if (err_count == 0 && other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- src/splicer.sv
`timescale 1ns/1ps

module splicer
  import splicer_pkg::*;
(
  input  logic   aclk,
  input  logic   aresetn,
  // input stream, tuser marks sof
  input  pixel_t s_axis_tdata,
  input  logic   s_axis_tvalid,
  input  logic   s_axis_tuser,
  input  logic   s_axis_tlast,
  output logic   s_axis_tready,
  // output stream, tuser on first pixel, tlast per line
  output pixel_t m_axis_tdata,
  output logic   m_axis_tvalid,
  output logic   m_axis_tuser,
  output logic   m_axis_tlast,
  input  logic   m_axis_tready
);

  logic      wr_en;
  pix_addr_t wr_addr;
  pixel_t    wr_data;
  logic      rd_en;
  pix_addr_t rd_addr;
  pixel_t    rd_data;
  logic      frame_full;
  logic      frame_release;
  fifo_cnt_t fifo_count;
  logic      push;
  out_beat_t push_beat;
  out_beat_t head;
  logic      head_valid;

  // s_axis_tlast has no role, line ends are rebuilt from the geometry

  frame_writer u_frame_writer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tready (s_axis_tready),
    .frame_release (frame_release),
    .frame_full    (frame_full),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data)
  );

  frame_ram u_frame_ram (
    .aclk    (aclk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  frame_reader u_frame_reader (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .frame_full    (frame_full),
    .frame_release (frame_release),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .fifo_count    (fifo_count),
    .push          (push),
    .push_beat     (push_beat)
  );

  stream_fifo u_stream_fifo (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push       (push),
    .push_beat  (push_beat),
    .pop_ready  (m_axis_tready),
    .head       (head),
    .head_valid (head_valid),
    .count      (fifo_count)
  );

  // fifo head drives the master port directly
  assign m_axis_tdata  = head.data;
  assign m_axis_tuser  = head.sof;
  assign m_axis_tlast  = head.eol;
  assign m_axis_tvalid = head_valid;

endmodule

//--- frame_buffer/frame_reader.sv
`timescale 1ns/1ps
`include "splicer_defines.svh"

module frame_reader
  import splicer_pkg::*;
(
  input  logic      aclk,
  input  logic      aresetn,
  // hand-off with the writer
  input  logic      frame_full,
  output logic      frame_release,
  // memory read port
  output logic      rd_en,
  output pix_addr_t rd_addr,
  input  pixel_t    rd_data,
  // output fifo
  input  fifo_cnt_t fifo_count,
  output logic      push,
  output out_beat_t push_beat
);

  localparam col_t  LAST_COL  = col_t'(`SPLICER_FRAME_WIDTH - 1);
  localparam line_t LAST_LINE = line_t'(`SPLICER_FRAME_HEIGHT - 1);

  rd_state_t state;
  col_t      col_cnt;
  line_t     line_cnt;
  logic      rd_en_q;
  logic      sof_q;
  logic      eol_q;
  logic      credit_ok;
  logic      eol_tag;
  logic      last_rd;

  //////////////////////////////////////////////////////////////////////
  // read issue
  //////////////////////////////////////////////////////////////////////

  // the beat pushed this cycle is not yet counted by the fifo
  assign credit_ok = (int'(fifo_count) + int'(rd_en_q)) < `SPLICER_FIFO_DEPTH;
  assign rd_en     = (state == PLAY) && credit_ok;

  assign eol_tag       = (col_cnt == LAST_COL);
  assign last_rd       = eol_tag && (line_cnt == LAST_LINE);
  assign frame_release = rd_en && last_rd;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= IDLE;
      rd_addr  <= '0;
      col_cnt  <= '0;
      line_cnt <= '0;
      rd_en_q  <= 1'b0;
    end else begin
      rd_en_q <= rd_en;
      unique case (state)
        IDLE: begin
          if (frame_full) begin
            state <= PLAY;
          end
        end
        PLAY: begin
          if (frame_release) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
      if (rd_en) begin
        if (last_rd) begin
          rd_addr  <= '0;
          col_cnt  <= '0;
          line_cnt <= '0;
        end else begin
          rd_addr <= rd_addr + 1'b1;
          if (eol_tag) begin
            col_cnt  <= '0;
            line_cnt <= line_cnt + 1'b1;
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sideband, delayed to meet rd_data
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (rd_en) begin
      sof_q <= (rd_addr == '0);
      eol_q <= eol_tag;
    end
  end

  assign push      = rd_en_q;
  assign push_beat = '{data: rd_data, sof: sof_q, eol: eol_q};

  a_push_has_room: assert property (@(posedge aclk) disable iff (!aresetn)
    push |-> (fifo_count < `SPLICER_FIFO_DEPTH))
    else $error("frame_reader: push into full fifo");

  // playback only from a frame the writer is holding
  a_read_held_frame: assert property (@(posedge aclk) disable iff (!aresetn)
    rd_en |-> frame_full)
    else $error("frame_reader: read without a held frame");

endmodule

//--- frame_buffer/frame_writer.sv
`timescale 1ns/1ps
`include "splicer_defines.svh"

module frame_writer
  import splicer_pkg::*;
(
  input  logic      aclk,
  input  logic      aresetn,
  // input stream
  input  pixel_t    s_axis_tdata,
  input  logic      s_axis_tvalid,
  input  logic      s_axis_tuser,
  output logic      s_axis_tready,
  // hand-off with the reader
  input  logic      frame_release,
  output logic      frame_full,
  // memory write port
  output logic      wr_en,
  output pix_addr_t wr_addr,
  output pixel_t    wr_data
);

  localparam pix_addr_t LAST_ADDR = pix_addr_t'(`SPLICER_FRAME_SIZE - 1);

  wr_state_t state;
  pix_addr_t fill_addr;
  logic      accept;
  logic      last_wr;

  //////////////////////////////////////////////////////////////////////
  // stream side
  //////////////////////////////////////////////////////////////////////

  // stall the source while a finished frame waits for playback
  assign s_axis_tready = (state != HOLD);
  assign accept        = s_axis_tvalid && s_axis_tready;

  // sof beats always land while other beats wait for alignment
  assign wr_en   = accept && (s_axis_tuser || state == FILL);
  assign wr_addr = s_axis_tuser ? '0 : fill_addr;
  assign wr_data = s_axis_tdata;
  assign last_wr = wr_en && (wr_addr == LAST_ADDR);

  assign frame_full = (state == HOLD);

  //////////////////////////////////////////////////////////////////////
  // fill FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state     <= SEEK;
      fill_addr <= '0;
    end else begin
      if (wr_en) begin
        fill_addr <= last_wr ? '0 : wr_addr + 1'b1;
      end
      unique case (state)
        SEEK, FILL: begin
          if (last_wr) begin
            state <= HOLD;
          end else if (wr_en) begin
            state <= FILL;
          end
        end
        HOLD: begin
          // frame_full drops the cycle after release
          if (frame_release) begin
            state <= SEEK;
          end
        end
        default: begin
          state <= SEEK;
        end
      endcase
    end
  end

  // the reader only lets go of a frame that is held
  a_release_when_full: assert property (@(posedge aclk) disable iff (!aresetn)
    frame_release |-> frame_full)
    else $error("frame_writer: release without a held frame");

endmodule

//--- frame_buffer/frame_ram.sv
`timescale 1ns/1ps
`include "splicer_defines.svh"

module frame_ram
  import splicer_pkg::*;
(
  input  logic      aclk,
  // write side, from the frame writer
  input  logic      wr_en,
  input  pix_addr_t wr_addr,
  input  pixel_t    wr_data,
  // read side, from the frame reader
  input  logic      rd_en,
  input  pix_addr_t rd_addr,
  output pixel_t    rd_data
);

  // one full frame, one pixel per word
  pixel_t mem [`SPLICER_FRAME_SIZE];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, data valid the cycle after rd_en
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // reads and writes never share a frame in time, the writer holds meanwhile

endmodule

//--- src/stream_fifo.sv
`timescale 1ns/1ps
`include "splicer_defines.svh"

module stream_fifo
  import splicer_pkg::*;
#(
  parameter int DEPTH = `SPLICER_FIFO_DEPTH
) (
  input  logic      aclk,
  input  logic      aresetn,
  input  logic      push,
  input  out_beat_t push_beat,
  input  logic      pop_ready,
  output out_beat_t head,
  output logic      head_valid,
  output fifo_cnt_t count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  out_beat_t mem [DEPTH];
  ptr_t      wr_ptr;
  ptr_t      rd_ptr;
  logic      pop;
  logic      full;

  // depth need not be a power of two
  function automatic ptr_t ptr_next(ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);
  assign full       = (count == fifo_cnt_t'(DEPTH));
  assign pop        = head_valid && pop_ready;

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= push_beat;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the reader's credit check must keep us from ever seeing this
  a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
    full |-> !push)
    else $error("stream_fifo: push while full");

endmodule

//--- common/splicer_pkg.sv
`include "splicer_defines.svh"

package splicer_pkg;

  localparam int PIXEL_W    = `SPLICER_PIXEL_W;
  localparam int PIX_ADDR_W = (`SPLICER_FRAME_SIZE > 1) ? $clog2(`SPLICER_FRAME_SIZE) : 1;
  localparam int COL_W      = (`SPLICER_FRAME_WIDTH > 1) ? $clog2(`SPLICER_FRAME_WIDTH) : 1;
  localparam int LINE_W     = (`SPLICER_FRAME_HEIGHT > 1) ? $clog2(`SPLICER_FRAME_HEIGHT) : 1;
  // holds 0 up to a full fifo
  localparam int FIFO_CNT_W = $clog2(`SPLICER_FIFO_DEPTH + 1);

  typedef logic [PIXEL_W-1:0]    pixel_t;
  typedef logic [PIX_ADDR_W-1:0] pix_addr_t;
  typedef logic [COL_W-1:0]      col_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

  // one beat on the master side
  typedef struct packed {
    pixel_t data;
    logic   sof;
    logic   eol;
  } out_beat_t;

  // writer: wait for sof, fill memory, hold until read out
  typedef enum logic [1:0] {
    SEEK,
    FILL,
    HOLD
  } wr_state_t;

  typedef enum logic {
    IDLE,
    PLAY
  } rd_state_t;

endpackage

//--- common/splicer_defines.svh
`ifndef SPLICER_DEFINES_SVH
`define SPLICER_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// pixel format
//////////////////////////////////////////////////////////////////////

`define SPLICER_PIXEL_W 48

//////////////////////////////////////////////////////////////////////
// frame geometry
//////////////////////////////////////////////////////////////////////

`define SPLICER_FRAME_WIDTH 8
`define SPLICER_FRAME_HEIGHT 4
`define SPLICER_FRAME_SIZE (`SPLICER_FRAME_WIDTH * `SPLICER_FRAME_HEIGHT)

// output beats buffered ahead of the master port
`define SPLICER_FIFO_DEPTH 4

`endif
